// File: bench/tb_camsync.sv
// camera sync testbench, register writes, gpio loopback and timestamp frame checks
module tb_camsync;
    import sync_regs_pkg::*;
    import ts_frame_pkg::*;

    // cycle budget per test, summed for the run limit
    localparam int T_RESET = 20;
    localparam int T_LINES = 20;
    localparam int T_SINGLE = 300;
    localparam int T_PLAIN = 300;
    localparam int T_REPEAT = 2000;
    localparam int T_LOOP = 5000;
    localparam int MARGIN = 1000;
    localparam int CYC_LIMIT = T_RESET + T_LINES + T_SINGLE + T_PLAIN + T_REPEAT
                               + T_LOOP + MARGIN;

    logic pclk = 1'b0;
    logic trigrst;
    logic wen;
    logic [ADDR_W-1:0] wa;
    logic [REG_W-1:0] di;
    logic triggered_mode;
    gpio_t gpio_in;
    logic ts_snd_en;
    logic ts_external;
    logic [SEC_W-1:0] ts_snd_sec;
    logic [USEC_W-1:0] ts_snd_usec;
    gpio_t gpio_out;
    gpio_t gpio_out_en;
    logic trigger1;
    logic trigger;
    logic overdue;
    logic [SEC_W-1:0] ts_rcv_sec;
    logic [USEC_W-1:0] ts_rcv_usec;
    logic ts_stb;

    int cyc = 0;           // posedges since start
    int wr_cyc;            // cyc just after the last write edge
    int errors = 0;
    int checks = 0;
    int t1_count = 0;      // trigger1 pulses seen
    int stb_count = 0;     // ts_stb pulses seen
    logic [31:0] lfsr = 32'h600d_534c;
    gpio_t out_en = 12'h8a1;  // output enables, line 0 included
    gpio_t out_lvl = 12'h0c1; // active levels, line 0 active high

    camsync_top UUT (.pclk, .trigrst, .wen, .wa, .di, .triggered_mode, .gpio_in,
        .ts_snd_en, .ts_external, .ts_snd_sec, .ts_snd_usec, .gpio_out, .gpio_out_en,
        .trigger1, .trigger, .overdue, .ts_rcv_sec, .ts_rcv_usec, .ts_stb);

    always #10 pclk = ~pclk;

    // loopback, undo the active level so the receiver sees the data level
    assign gpio_in = ~(gpio_out ^ out_lvl);

    always @(posedge pclk) begin
        cyc <= cyc + 1;
        if (cyc >= CYC_LIMIT) begin
            $display("Timeout: run passed the cycle limit of %0d", CYC_LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    always @(negedge pclk) begin
        if (trigger1) t1_count <= t1_count + 1;  // one-cycle pulses, one sample each
        if (ts_stb) stb_count <= stb_count + 1;
    end

    // galois form, right shift
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("Error: time %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic fail_msg(input string what);
        errors++;
        $display("Error: time %0t %s", $time, what);
    endtask

    task automatic write_reg(input logic [ADDR_W-1:0] a, input logic [REG_W-1:0] d);
        @(negedge pclk);
        wen = 1'b1;
        wa = a;
        di = d;
        @(negedge pclk);
        wen = 1'b0;
        wr_cyc = cyc;  // write edge already counted
    endtask

    // interleave enable/use and level bits into a pair word
    function automatic logic [REG_W-1:0] pairs(input gpio_t hi, input gpio_t lo);
        pairs = '0;
        for (int i = 0; i < GPIO_W; i++) begin
            pairs[2*i+1] = hi[i];
            pairs[2*i] = lo[i];
        end
    endfunction

    task automatic wait_trigger1(input int limit, output bit ok);
        int n;
        n = 0;
        ok = 1'b0;
        while (n < limit && !ok) begin
            @(negedge pclk);
            ok = trigger1;
            n++;
        end
        if (!ok) fail_msg("trigger1 never pulsed");
    endtask

    task automatic report(input int num, input string name, input int err_before);
        $display("test %0d %s: %s", num, name, (errors == err_before) ? "ok" : "FAILED");
    endtask

    initial begin
        int e0;
        int n;
        int c0;
        int len;
        int t_at[4];
        bit ok;
        logic [31:0] r;
        logic [SEC_W-1:0] exp_sec;
        logic [USEC_W-1:0] exp_usec;

        trigrst = 1'b1;
        wen = 1'b0;
        wa = '0;
        di = '0;
        triggered_mode = 1'b0;
        ts_snd_en = 1'b0;
        ts_external = 1'b0;
        ts_snd_sec = '0;
        ts_snd_usec = '0;
        repeat (3) @(posedge pclk);
        @(negedge pclk);
        trigrst = 1'b0;

        // 1 reset state
        e0 = errors;
        check_val("trigger", trigger, 0);
        check_val("overdue", overdue, 0);
        check_val("trigger1", trigger1, 0);
        check_val("ts_stb", ts_stb, 0);
        check_val("gpio_out_en", gpio_out_en, 0);
        report(1, "reset state", e0);

        // 2 output lines at rest
        e0 = errors;
        write_reg(REG_OUTPUT, pairs(out_en, out_lvl));
        check_val("gpio_out_en", gpio_out_en, out_en);
        check_val("gpio_out", gpio_out, gpio_t'(~out_lvl));  // idle shows the inactive level
        report(2, "output lines at rest", e0);

        // 3 single internal start, then overdue on the second one
        e0 = errors;
        write_reg(REG_INPUT, '0);
        write_reg(REG_PERIOD, 32'd3);  // bit length 3
        c0 = t1_count;
        write_reg(REG_PERIOD, 32'd1);
        wait_trigger1(50, ok);
        check_val("trigger1 latency", cyc - wr_cyc, 2);
        @(negedge pclk);
        check_val("trigger", trigger, 1);
        check_val("overdue", overdue, 0);
        repeat (60) @(negedge pclk);
        check_val("trigger1 pulses", t1_count - c0, 1);
        write_reg(REG_PERIOD, 32'd1);
        wait_trigger1(50, ok);
        @(negedge pclk);
        check_val("overdue", overdue, 1);  // trigger was still high
        repeat (60) @(negedge pclk);
        report(3, "single internal start", e0);

        // 4 plain pulse, 4 bits of 4 cycles
        e0 = errors;
        write_reg(REG_PERIOD, 32'd1);
        n = 0;
        while (n < 100 && gpio_out[0] != out_lvl[0]) begin
            @(negedge pclk);
            n++;
        end
        if (gpio_out[0] != out_lvl[0]) fail_msg("plain pulse never started");
        len = 0;
        while (len < 200 && gpio_out[0] == out_lvl[0]) begin
            @(negedge pclk);
            len++;
        end
        check_val("pulse length", len, 4 * (3 + 1));
        report(4, "plain pulse length", e0);

        // 5 repetitive start every 300 cycles, then stop
        e0 = errors;
        write_reg(REG_PERIOD, 32'd300);
        for (int k = 0; k < 4; k++) begin
            wait_trigger1(400, ok);
            t_at[k] = cyc;
        end
        for (int k = 1; k < 4; k++)
            check_val("trigger1 period", t_at[k] - t_at[k-1], 300);
        write_reg(REG_PERIOD, 32'd0);
        repeat (3) @(negedge pclk);  // a start already in flight may land
        c0 = t1_count;
        repeat (700) @(negedge pclk);
        check_val("trigger1 after stop", t1_count - c0, 0);
        report(5, "repetitive start", e0);

        // 6 external timestamp loopback on line 0
        e0 = errors;
        take_bits(SEC_W, r);
        exp_sec = r;
        take_bits(USEC_W, r);
        exp_usec = r[USEC_W-1:0];
        @(negedge pclk);
        triggered_mode = 1'b1;
        ts_snd_en = 1'b1;
        ts_external = 1'b1;
        ts_snd_sec = exp_sec;
        ts_snd_usec = exp_usec;
        write_reg(REG_PERIOD, 32'd15);   // 16 cycles per bit
        write_reg(REG_INPUT, 32'd3);     // line 0 used, level high
        repeat (5) @(negedge pclk);
        c0 = stb_count;
        write_reg(REG_PERIOD, 32'd1);
        n = 0;
        while (n < 3000 && !ts_stb) begin
            @(negedge pclk);
            n++;
        end
        if (!ts_stb) begin
            fail_msg("ts_stb never fired after the frame");
        end else begin
            check_val("ts_rcv_sec", ts_rcv_sec, exp_sec);
            check_val("ts_rcv_usec", ts_rcv_usec, exp_usec);
        end
        repeat (1200) @(negedge pclk);
        check_val("ts_stb pulses", stb_count - c0, 1);
        report(6, "external timestamp loopback", e0);

        $display("tests: 6, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: project.f
verilog/sync_regs_pkg.sv
verilog/ts_frame_pkg.sv
verilog/sync_regs.sv
verilog/trig_input.sv
verilog/period_gen.sv
verilog/trig_delay.sv
verilog/ts_sender.sv
verilog/ts_receiver.sv
verilog/camsync_top.sv
bench/tb_camsync.sv

// File: run_sim.sh
#!/bin/sh
# build and run the camera sync testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f project.f \
    --top-module tb_camsync \
    --Mdir obj_dir \
    -o sim_camsync

./obj_dir/sim_camsync | tee sim.log

if grep -q "^No errors$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// File: verilog/camsync_top.sv
// camera synchronization top, register port, trigger path and timestamp sync line
module camsync_top (
    input  logic                                pclk,
    input  logic                                trigrst,
    input  logic                                wen,
    input  logic [sync_regs_pkg::ADDR_W-1:0]    wa,
    input  logic [sync_regs_pkg::REG_W-1:0]     di,
    input  logic                                triggered_mode,
    input  sync_regs_pkg::gpio_t                gpio_in,
    input  logic                                ts_snd_en,
    input  logic                                ts_external,
    input  logic [ts_frame_pkg::SEC_W-1:0]      ts_snd_sec,
    input  logic [ts_frame_pkg::USEC_W-1:0]     ts_snd_usec,
    output sync_regs_pkg::gpio_t                gpio_out,
    output sync_regs_pkg::gpio_t                gpio_out_en,
    output logic                                trigger1,
    output logic                                trigger,
    output logic                                overdue,
    output logic [ts_frame_pkg::SEC_W-1:0]      ts_rcv_sec,
    output logic [ts_frame_pkg::USEC_W-1:0]     ts_rcv_usec,
    output logic                                ts_stb
);
    import sync_regs_pkg::*;

    gpio_t input_use;
    gpio_t input_pattern;
    gpio_t gpio_active;
    dly_t  input_dly;
    dly_t  repeat_period;
    blen_t bit_length;
    logic  use_intern;
    logic  rep_en;
    logic  start_en;
    logic  start;
    logic  gen_start;  // internal start strobe
    logic  cond_filt;  // filtered input line
    logic  rcv_start;  // received frame start
    logic  dly_done;   // end of the trigger delay

    sync_regs i_regs (.pclk, .trigrst, .wen, .wa, .di, .input_use, .input_pattern,
        .gpio_out_en, .gpio_active, .use_intern, .input_dly, .repeat_period,
        .bit_length, .rep_en, .start_en, .start);

    trig_input i_input (.pclk, .trigrst, .triggered_mode, .use_intern, .gpio_in,
        .input_use, .input_pattern, .bit_length, .cond_filt);

    period_gen i_period (.pclk, .trigrst, .start, .rep_en, .start_en, .repeat_period,
        .gen_start);

    trig_delay i_delay (.pclk, .trigrst, .triggered_mode, .use_intern, .gen_start,
        .rcv_start, .input_dly, .dly_done, .trigger1, .trigger, .overdue);

    ts_sender i_sender (.pclk, .trigrst, .use_intern, .gen_start, .dly_done, .start_en,
        .ts_snd_en, .bit_length, .gpio_active, .ts_snd_sec, .ts_snd_usec, .gpio_out);

    ts_receiver i_receiver (.pclk, .trigrst, .triggered_mode, .start_en, .ts_external,
        .use_intern, .cond_filt, .trigger1, .bit_length, .ts_snd_sec, .ts_snd_usec,
        .rcv_start, .ts_rcv_sec, .ts_rcv_usec, .ts_stb);

endmodule

// File: verilog/period_gen.sv
// start generator, single or repetitive starts with an exact period
module period_gen (
    input  logic                pclk,
    input  logic                trigrst,
    input  logic                start,
    input  logic                rep_en,
    input  logic                start_en,
    input  sync_regs_pkg::dly_t repeat_period,
    output logic                gen_start
);
    import sync_regs_pkg::*;

    dly_t cnt;      // cycles left in the current period
    logic run;      // period counter active
    logic restart;  // period elapsed

    // reload at cnt==1 so that starts are exactly repeat_period apart
    assign restart = run && (cnt == dly_t'(1));

    always_ff @(posedge pclk) begin
        if (trigrst || !start_en) begin  // stop write halts at once
            gen_start <= 1'b0;
            run       <= 1'b0;
            cnt       <= '0;
        end else begin
            gen_start <= start || restart;
            if (start || restart) begin
                cnt <= repeat_period;
                run <= rep_en;          // single start does not rearm
            end else if (run) begin
                cnt <= cnt - dly_t'(1);
            end
        end
    end

endmodule

// File: verilog/sync_regs.sv
// sync control registers
// splits bit-pair words into fields, sorts period writes into commands
module sync_regs (
    input  logic                             pclk,
    input  logic                             trigrst,
    input  logic                             wen,
    input  logic [sync_regs_pkg::ADDR_W-1:0] wa,
    input  logic [sync_regs_pkg::REG_W-1:0]  di,
    output sync_regs_pkg::gpio_t             input_use,
    output sync_regs_pkg::gpio_t             input_pattern,
    output sync_regs_pkg::gpio_t             gpio_out_en,
    output sync_regs_pkg::gpio_t             gpio_active,
    output logic                             use_intern,
    output sync_regs_pkg::dly_t              input_dly,
    output sync_regs_pkg::dly_t              repeat_period,
    output sync_regs_pkg::blen_t             bit_length,
    output logic                             rep_en,
    output logic                             start_en,
    output logic                             start
);
    import sync_regs_pkg::*;

    gpio_t pair_hi;   // odd bits: use / enable
    gpio_t pair_lo;   // even bits: level
    logic  per_wr;
    logic  is_blen;   // 2..255 only sets the bit length
    logic  is_start;  // single or repetitive start

    for (genvar i = 0; i < GPIO_W; i++) begin : g_pairs
        assign pair_hi[i] = di[2*i+1];
        assign pair_lo[i] = di[2*i];
    end

    assign per_wr   = wen && (wa == REG_PERIOD);
    assign is_blen  = (di > CMD_SINGLE) && (di < CMD_REPEAT_MIN);
    assign is_start = (di == CMD_SINGLE) || (di >= CMD_REPEAT_MIN);

    always_ff @(posedge pclk) begin
        if (trigrst) begin
            input_use     <= '0;
            input_pattern <= '0;
            use_intern    <= 1'b1;  // no input lines selected
            input_dly     <= '0;
            gpio_out_en   <= '0;
            gpio_active   <= '0;
            repeat_period <= '0;
            bit_length    <= BLEN_RESET;
            rep_en        <= 1'b0;
            start_en      <= 1'b0;
            start         <= 1'b0;
        end else begin
            start <= per_wr && is_start;  // one cycle strobe after the write
            if (wen && (wa == REG_INPUT)) begin
                input_use     <= pair_hi;
                input_pattern <= pair_lo;
                use_intern    <= (pair_hi == '0);
            end
            if (wen && (wa == REG_DELAY))
                input_dly <= di;
            if (wen && (wa == REG_OUTPUT)) begin
                gpio_out_en <= pair_hi;
                gpio_active <= pair_lo;
            end
            if (per_wr && is_blen)
                bit_length <= blen_t'(di);
            if (per_wr && !is_blen) begin  // stop, single or repeat
                repeat_period <= di;
                rep_en        <= (di >= CMD_REPEAT_MIN);
                start_en      <= (di != '0);
            end
        end
    end

endmodule

// File: verilog/sync_regs_pkg.sv
// camera sync register map, control field widths and period command thresholds
package sync_regs_pkg;

    localparam int GPIO_W = 12;  // gpio lines
    localparam int REG_W  = 32;  // control data width
    localparam int ADDR_W = 2;   // four registers
    localparam int BLEN_W = 8;   // bit length field

    typedef logic [GPIO_W-1:0] gpio_t;
    typedef logic [REG_W-1:0]  dly_t;   // delay and period counts, pclk cycles
    typedef logic [BLEN_W-1:0] blen_t;  // bit duration minus one

    // register addresses
    localparam logic [ADDR_W-1:0] REG_INPUT  = 2'd0;  // 12 pairs (use, level)
    localparam logic [ADDR_W-1:0] REG_DELAY  = 2'd1;  // trigger delay
    localparam logic [ADDR_W-1:0] REG_OUTPUT = 2'd2;  // 12 pairs (enable, active level)
    localparam logic [ADDR_W-1:0] REG_PERIOD = 2'd3;  // period / command word

    // period word: 0 stop, 1 single, 2..255 bit length, above that repeat
    localparam dly_t  CMD_SINGLE     = 32'd1;
    localparam dly_t  CMD_REPEAT_MIN = 32'd256;
    localparam blen_t BLEN_RESET     = 8'd255;

endpackage

// File: verilog/trig_delay.sv
// trigger delay counter, trigger1, toggling sensor trigger and overdue flag
module trig_delay (
    input  logic                pclk,
    input  logic                trigrst,
    input  logic                triggered_mode,
    input  logic                use_intern,
    input  logic                gen_start,
    input  logic                rcv_start,
    input  sync_regs_pkg::dly_t input_dly,
    output logic                dly_done,
    output logic                trigger1,
    output logic                trigger,
    output logic                overdue
);
    import sync_regs_pkg::*;

    dly_t cnt;
    logic run;
    logic run_d;
    logic start_dly;  // internal start or received frame start

    assign start_dly = use_intern ? gen_start : rcv_start;
    assign dly_done  = run_d && !run;  // falling edge of the run flag

    always_ff @(posedge pclk) begin
        if (trigrst) begin
            run      <= 1'b0;
            run_d    <= 1'b0;
            trigger1 <= 1'b0;
            trigger  <= 1'b0;
            overdue  <= 1'b0;
        end else begin
            run      <= (use_intern || triggered_mode) &&
                        (start_dly || (run && (cnt != '0)));
            run_d    <= run;
            trigger1 <= use_intern ? gen_start : dly_done;  // internal skips the delay
            trigger  <= trigger ^ trigger1;  // toggle, a lost frame end cannot lock it
            if (trigger1)
                overdue <= trigger;          // still high from the previous one
        end
    end

    // loaded while idle
    always_ff @(posedge pclk) begin
        if (run)
            cnt <= cnt - dly_t'(1);
        else
            cnt <= input_dly;
    end

endmodule

// File: verilog/trig_input.sv
// gpio trigger input, pattern match and quarter-bit glitch filter
module trig_input (
    input  logic                 pclk,
    input  logic                 trigrst,
    input  logic                 triggered_mode,
    input  logic                 use_intern,
    input  sync_regs_pkg::gpio_t gpio_in,
    input  sync_regs_pkg::gpio_t input_use,
    input  sync_regs_pkg::gpio_t input_pattern,
    input  sync_regs_pkg::blen_t bit_length,
    output logic                 cond_filt
);
    logic       cond;      // all used lines at their level
    logic       cond_d;    // for change detect
    logic [6:0] filt_cnt;  // bit 6 set once the quarter bit has expired

    always_ff @(posedge pclk) begin
        if (trigrst) begin
            cond      <= 1'b0;
            cond_d    <= 1'b0;
            filt_cnt  <= '0;
            cond_filt <= 1'b0;
        end else begin
            cond   <= ((gpio_in ^ input_pattern) & input_use) == '0;
            cond_d <= cond;

            // every change restarts the quarter-bit wait
            if (!triggered_mode || (cond != cond_d))
                filt_cnt <= {1'b0, bit_length[7:2]};
            else if (!filt_cnt[6])
                filt_cnt <= filt_cnt - 7'd1;

            if (use_intern || !triggered_mode)
                cond_filt <= 1'b0;   // line ignored
            else if (filt_cnt[6])
                cond_filt <= cond_d; // stable long enough
        end
    end

endmodule

// File: verilog/ts_frame_pkg.sv
// timestamp frame layout for the serial sync line
package ts_frame_pkg;

    localparam int SEC_W      = 32;  // seconds
    localparam int USEC_W     = 20;  // microseconds
    localparam int MAGIC_W    = 6;
    localparam int FRAME_BITS = 64;  // pre magic, sec, usec, post magic
    localparam int PLAIN_BITS = 4;   // plain pulse length in bits

    localparam logic [MAGIC_W-1:0] PRE_MAGIC  = 6'b110100;
    localparam logic [MAGIC_W-1:0] POST_MAGIC = 6'b001101;

    // reported usec when either magic is wrong
    localparam logic [USEC_W-1:0] USEC_ERR = '1;

endpackage

// File: verilog/ts_receiver.sv
// sync line receiver, decodes the timestamp frame and checks both magics
// falls back to the local timestamp at trigger1
module ts_receiver (
    input  logic                             pclk,
    input  logic                             trigrst,
    input  logic                             triggered_mode,
    input  logic                             start_en,
    input  logic                             ts_external,
    input  logic                             use_intern,
    input  logic                             cond_filt,
    input  logic                             trigger1,
    input  sync_regs_pkg::blen_t             bit_length,
    input  logic [ts_frame_pkg::SEC_W-1:0]   ts_snd_sec,
    input  logic [ts_frame_pkg::USEC_W-1:0]  ts_snd_usec,
    output logic                             rcv_start,
    output logic [ts_frame_pkg::SEC_W-1:0]   ts_rcv_sec,
    output logic [ts_frame_pkg::USEC_W-1:0]  ts_rcv_usec,
    output logic                             ts_stb
);
    import sync_regs_pkg::*;
    import ts_frame_pkg::*;

    logic                  active;     // run or deaf period
    logic                  run;        // 64 data bits
    logic                  run_d;
    logic                  ts_ext;     // external timestamp in use
    logic                  rq;         // copy requested, waits for the run end
    logic                  rq_d;
    logic                  done;
    logic                  err;        // magic mismatch
    logic [8:0]            len_p1;
    blen_t                 bit_short;  // 3/4 bit minus one
    blen_t                 dur;
    logic [6:0]            cnt;        // 127..64 data, 63..0 deaf
    logic [FRAME_BITS-1:0] sr;

    assign len_p1    = {1'b0, bit_length} + 9'd1;
    assign bit_short = bit_length - blen_t'(len_p1[8:2]) - blen_t'(1);

    assign run       = active && cnt[6];
    assign rcv_start = run && !run_d;
    assign ts_ext    = ts_external && !use_intern;
    assign done      = rq_d && !rq;
    assign err       = (sr[FRAME_BITS-1 -: MAGIC_W] != PRE_MAGIC) ||
                       (sr[MAGIC_W-1:0] != POST_MAGIC);

    always_ff @(posedge pclk) begin
        if (trigrst) begin
            active <= 1'b0;
            run_d  <= 1'b0;
            rq     <= 1'b0;
            rq_d   <= 1'b0;
            ts_stb <= 1'b0;
        end else begin
            // new edges ignored until 128 bit times have passed
            active <= start_en && (active ? !((dur == '0) && (cnt == '0)) : cond_filt);
            run_d  <= run;
            rq     <= start_en && ((ts_ext && trigger1) || (rq && run));
            rq_d   <= rq;
            ts_stb <= done || (!ts_ext && trigger1);
        end
    end

    always_ff @(posedge pclk) begin
        if (!active)
            dur <= bit_short;  // first sample at 3/4 of the bit
        else if (dur == '0)
            dur <= bit_length;
        else
            dur <= dur - blen_t'(1);

        if (!active)
            cnt <= '1;
        else if (dur == '0)
            cnt <= cnt - 7'd1;

        if (run && (dur == '0))
            sr <= {sr[FRAME_BITS-2:0], cond_filt};

        if (done) begin
            ts_rcv_sec  <= sr[FRAME_BITS-MAGIC_W-1 -: SEC_W];
            ts_rcv_usec <= err ? USEC_ERR : sr[MAGIC_W +: USEC_W];
        end else if (!triggered_mode || (!ts_ext && trigger1)) begin
            ts_rcv_sec  <= ts_snd_sec;   // local timestamp
            ts_rcv_usec <= ts_snd_usec;
        end
    end

endmodule

// File: verilog/ts_sender.sv
// sync line sender, plain pulse or 64-bit timestamp frame MSB first
module ts_sender (
    input  logic                                pclk,
    input  logic                                trigrst,
    input  logic                                use_intern,
    input  logic                                gen_start,
    input  logic                                dly_done,
    input  logic                                start_en,
    input  logic                                ts_snd_en,
    input  sync_regs_pkg::blen_t                bit_length,
    input  sync_regs_pkg::gpio_t                gpio_active,
    input  logic [ts_frame_pkg::SEC_W-1:0]      ts_snd_sec,
    input  logic [ts_frame_pkg::USEC_W-1:0]     ts_snd_usec,
    output sync_regs_pkg::gpio_t                gpio_out
);
    import sync_regs_pkg::*;
    import ts_frame_pkg::*;

    logic                  outsync;  // frame or pulse in progress
    logic                  go;
    logic                  last;     // end of the final bit
    logic                  data;
    blen_t                 dur;      // cycles left in this bit
    logic [5:0]            bcnt;     // bits left
    logic [FRAME_BITS-1:0] sr;

    assign go   = use_intern ? dly_done : gen_start;
    assign last = (dur == '0) && (bcnt == '0);
    assign data = outsync && (ts_snd_en ? sr[FRAME_BITS-1] : 1'b1);

    assign gpio_out = data ? gpio_active : ~gpio_active;  // idle is the inactive level

    always_ff @(posedge pclk) begin
        if (trigrst)
            outsync <= 1'b0;
        else
            outsync <= start_en && (outsync ? !last : go);  // busy drops new starts
    end

    always_ff @(posedge pclk) begin
        if (!outsync || (dur == '0))
            dur <= bit_length;
        else
            dur <= dur - blen_t'(1);

        if (!outsync)
            bcnt <= ts_snd_en ? 6'(FRAME_BITS - 1) : 6'(PLAIN_BITS - 1);
        else if (dur == '0)
            bcnt <= bcnt - 6'd1;

        if (!outsync)  // snapshot of the timestamp while idle
            sr <= {PRE_MAGIC, ts_snd_sec, ts_snd_usec, POST_MAGIC};
        else if (dur == '0)
            sr <= {sr[FRAME_BITS-2:0], 1'b0};
    end

endmodule
